// ==== hdl/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

////////////////////////////////////////////////////////////
// Execute stage widths
////////////////////////////////////////////////////////////

// Data and address width
`define XLEN 32

// Destination register index
`define REG_ADDR_W 5

// One quotient bit per iteration
`define DIV_STEPS 32

`endif

// ==== hdl/ex_op_pkg.sv ====
package ex_op_pkg;

    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_LUI, OP_PCADD,
        OP_MUL, OP_MULH, OP_MULHU,
        OP_DIV, OP_DIVU, OP_MOD, OP_MODU,
        OP_LDB, OP_LDH, OP_LDW, OP_STB, OP_STH, OP_STW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JIRL,
        OP_NOP
    } ex_op_e;

    // Where the write data comes from
    typedef enum logic [2:0] {
        RES_LOGIC,
        RES_SHIFT,
        RES_ARITH,
        RES_MOVE,
        RES_MUL,
        RES_DIV,
        RES_LINK,
        RES_NONE
    } res_class_e;

    function automatic res_class_e op_class(ex_op_e op);
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOR:          return RES_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:                 return RES_SHIFT;
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU:        return RES_ARITH;
            OP_LUI, OP_PCADD:                       return RES_MOVE;
            OP_MUL, OP_MULH, OP_MULHU:              return RES_MUL;
            OP_DIV, OP_DIVU, OP_MOD, OP_MODU:       return RES_DIV;
            OP_JIRL:                                return RES_LINK;
            default:                                return RES_NONE;
        endcase
    endfunction

    function automatic logic is_mul(ex_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHU};
    endfunction

    function automatic logic is_div(ex_op_e op);
        return op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
    endfunction

    function automatic logic is_load(ex_op_e op);
        return op inside {OP_LDB, OP_LDH, OP_LDW};
    endfunction

    function automatic logic is_store(ex_op_e op);
        return op inside {OP_STB, OP_STH, OP_STW};
    endfunction

    // Jumps count as branches here
    function automatic logic is_branch(ex_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JIRL};
    endfunction

endpackage

// ==== hdl/ex_bus_pkg.sv ====
package ex_bus_pkg;

    // Memory access width
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

    // Multiplier word select
    typedef enum logic [1:0] {
        MK_LO          = 2'd0,
        MK_HI_SIGNED   = 2'd1,
        MK_HI_UNSIGNED = 2'd2
    } mul_kind_e;

    // Bit 0 marks unsigned, bit 1 marks remainder
    typedef enum logic [1:0] {
        DK_QUOT_S = 2'd0,
        DK_QUOT_U = 2'd1,
        DK_REM_S  = 2'd2,
        DK_REM_U  = 2'd3
    } div_kind_e;

endpackage

// ==== hdl/alu.sv ====
`include "ex_macros.svh"

module alu (
    input  ex_op_pkg::ex_op_e  op_i,
    input  logic [`XLEN-1:0]   src1_i,
    input  logic [`XLEN-1:0]   src2_i,
    input  logic [`XLEN-1:0]   imm_i,
    input  logic [`XLEN-1:0]   pc_i,
    output logic [`XLEN-1:0]   logic_o,
    output logic [`XLEN-1:0]   shift_o,
    output logic [`XLEN-1:0]   arith_o,
    output logic [`XLEN-1:0]   move_o,
    output logic               taken_o,
    output logic [`XLEN-1:0]   target_o
);
    import ex_op_pkg::*;

    logic                       eq;
    logic                       lt_s;
    logic                       lt_u;
    logic [$clog2(`XLEN)-1:0]   shamt;

    assign eq    = src1_i == src2_i;
    assign lt_s  = $signed(src1_i) < $signed(src2_i);
    assign lt_u  = src1_i < src2_i;
    assign shamt = src2_i[$clog2(`XLEN)-1:0];

    always_comb begin
        case (op_i)
            OP_OR:   logic_o = src1_i | src2_i;
            OP_XOR:  logic_o = src1_i ^ src2_i;
            OP_NOR:  logic_o = ~(src1_i | src2_i);
            default: logic_o = src1_i & src2_i;
        endcase
    end

    always_comb begin
        case (op_i)
            OP_SRL:  shift_o = src1_i >> shamt;
            OP_SRA:  shift_o = $signed(src1_i) >>> shamt;
            default: shift_o = src1_i << shamt;
        endcase
    end

    always_comb begin
        case (op_i)
            OP_SUB:  arith_o = src1_i - src2_i;
            OP_SLT:  arith_o = {{(`XLEN-1){1'b0}}, lt_s};
            OP_SLTU: arith_o = {{(`XLEN-1){1'b0}}, lt_u};
            default: arith_o = src1_i + src2_i;
        endcase
    end

    // LUI operand arrives already shifted
    assign move_o = (op_i == OP_LUI) ? src2_i : src2_i + pc_i;

    ////////////////////////////////////////////////////////////
    // Branch evaluation
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            OP_BEQ:  taken_o = eq;
            OP_BNE:  taken_o = !eq;
            OP_BLT:  taken_o = lt_s;
            OP_BGE:  taken_o = !lt_s;
            OP_BLTU: taken_o = lt_u;
            OP_BGEU: taken_o = !lt_u;
            OP_JIRL: taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    // Register-relative for JIRL, pc-relative otherwise
    assign target_o = ((op_i == OP_JIRL) ? src1_i : pc_i) + imm_i;

endmodule

// ==== hdl/mul_unit.sv ====
`include "ex_macros.svh"

module mul_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  logic                   cancel_i,
    input  ex_bus_pkg::mul_kind_e  kind_i,
    input  logic [`XLEN-1:0]       a_i,
    input  logic [`XLEN-1:0]       b_i,
    output logic                   done_o,
    output logic [`XLEN-1:0]       result_o
);
    import ex_bus_pkg::*;

    logic                   ext_signed;
    logic [`XLEN:0]         a_ext;
    logic [`XLEN:0]         b_ext;
    logic                   s1_valid_q;
    logic                   s2_valid_q;
    mul_kind_e              kind_q;
    logic [2*`XLEN+1:0]     prod_q;

    // Low word is the same either way
    assign ext_signed = kind_i != MK_HI_UNSIGNED;
    assign a_ext = {ext_signed && a_i[`XLEN-1], a_i};
    assign b_ext = {ext_signed && b_i[`XLEN-1], b_i};

    always_ff @(posedge clk) begin
        if (rst || cancel_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= start_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            prod_q <= $signed(a_ext) * $signed(b_ext);
            kind_q <= kind_i;
        end
        if (s1_valid_q) begin
            result_o <= (kind_q == MK_LO) ? prod_q[`XLEN-1:0] : prod_q[2*`XLEN-1:`XLEN];
        end
    end

    assign done_o = s2_valid_q;

    // Fed one operation at a time
    assert property (@(posedge clk) disable iff (rst) done_o |=> !done_o);

endmodule

// ==== hdl/div_unit.sv ====
`include "ex_macros.svh"

module div_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  logic                   cancel_i,
    input  ex_bus_pkg::div_kind_e  kind_i,
    input  logic [`XLEN-1:0]       dividend_i,
    input  logic [`XLEN-1:0]       divisor_i,
    output logic                   busy_o,
    output logic                   done_o,
    output logic [`XLEN-1:0]       quot_o,
    output logic [`XLEN-1:0]       rem_o
);
    import ex_bus_pkg::*;

    localparam int CNT_W = $clog2(`DIV_STEPS + 1);

    logic               busy_q;
    logic               done_q;
    logic [CNT_W-1:0]   cnt_q;
    logic [`XLEN-1:0]   quot_q;
    logic [`XLEN-1:0]   rem_q;
    logic [`XLEN-1:0]   dsor_q;
    logic               neg_quot_q;
    logic               neg_rem_q;
    logic               zero_q;

    logic               is_signed;
    logic               a_neg;
    logic               b_neg;
    logic               last;
    logic [`XLEN:0]     shifted;
    logic [`XLEN+1:0]   diff;
    logic               fit;

    assign is_signed = (kind_i == DK_QUOT_S) || (kind_i == DK_REM_S);
    assign a_neg = is_signed && dividend_i[`XLEN-1];
    assign b_neg = is_signed && divisor_i[`XLEN-1];

    // Iterations done, next edge is the sign fix-up
    assign last = cnt_q == CNT_W'(`DIV_STEPS);

    // Shift in next dividend bit and trial subtract
    assign shifted = {rem_q, quot_q[`XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dsor_q};
    assign fit     = !diff[`XLEN+1];

    always_ff @(posedge clk) begin
        if (rst || cancel_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= busy_q && last;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (last) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Magnitude datapath
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start_i) begin
            quot_q     <= a_neg ? -dividend_i : dividend_i;
            rem_q      <= '0;
            dsor_q     <= b_neg ? -divisor_i : divisor_i;
            neg_quot_q <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;
            zero_q     <= divisor_i == '0;
        end else if (busy_q && !last) begin
            quot_q <= {quot_q[`XLEN-2:0], fit};
            rem_q  <= fit ? diff[`XLEN-1:0] : shifted[`XLEN-1:0];
        end
        // Remainder takes the dividend's sign, zero divisor included
        if (busy_q && last) begin
            quot_o <= zero_q ? '1 : (neg_quot_q ? -quot_q : quot_q);
            rem_o  <= neg_rem_q ? -rem_q : rem_q;
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;

    // Stage must wait for done before the next divide
    assert property (@(posedge clk) disable iff (rst) start_i |-> !busy_o);

endmodule

// ==== hdl/ex_stage.sv ====
`include "ex_macros.svh"

module ex_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  ex_op_pkg::ex_op_e       op_i,
    input  logic [`XLEN-1:0]        src1_i,
    input  logic [`XLEN-1:0]        src2_i,
    input  logic [`XLEN-1:0]        imm_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`REG_ADDR_W-1:0]  rd_i,
    input  logic                    wen_i,
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output logic [`XLEN-1:0]        wdata_o,
    output logic [`REG_ADDR_W-1:0]  waddr_o,
    output logic                    wen_o,
    output logic [`XLEN-1:0]        mem_addr_o,
    output logic [`XLEN-1:0]        store_data_o,
    output logic                    mem_load_o,
    output logic                    mem_store_o,
    output ex_bus_pkg::mem_size_e   mem_size_o,
    output logic                    excp_ale_o,
    output logic                    redirect_o,
    output logic [`XLEN-1:0]        redirect_target_o
);
    import ex_op_pkg::*;
    import ex_bus_pkg::*;

    // Latched instruction
    logic                   busy_q;
    logic                   first_q;
    ex_op_e                 op_q;
    logic [`XLEN-1:0]       src1_q;
    logic [`XLEN-1:0]       src2_q;
    logic [`XLEN-1:0]       imm_q;
    logic [`XLEN-1:0]       pc_q;
    logic [`REG_ADDR_W-1:0] rd_q;
    logic                   wen_q;

    logic                   mul_start_q;
    logic                   div_start_q;
    logic                   mul_done;
    logic                   div_done;
    logic                   div_busy;
    logic [`XLEN-1:0]       mul_result;
    logic [`XLEN-1:0]       div_quot;
    logic [`XLEN-1:0]       div_rem;
    mul_kind_e              mul_kind;
    div_kind_e              div_kind;

    logic [`XLEN-1:0]       alu_logic;
    logic [`XLEN-1:0]       alu_shift;
    logic [`XLEN-1:0]       alu_arith;
    logic [`XLEN-1:0]       alu_move;
    logic [`XLEN-1:0]       alu_target;
    logic                   alu_taken;

    res_class_e             res_class;
    logic                   accept;
    logic                   unit_done;
    logic                   complete;
    logic [`XLEN-1:0]       wdata;
    logic [`XLEN-1:0]       mem_addr;
    mem_size_e              mem_size;
    logic                   ale;

    ////////////////////////////////////////////////////////////
    // Input handshake and unit launch
    ////////////////////////////////////////////////////////////

    assign in_ready_o = !busy_q && !div_busy && (!out_valid_o || out_ready_i);
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            busy_q      <= 1'b0;
            first_q     <= 1'b0;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
        end else begin
            first_q     <= accept;
            mul_start_q <= first_q && is_mul(op_q);
            div_start_q <= first_q && is_div(op_q);
            if (accept) begin
                busy_q <= 1'b1;
            end else if (complete) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= op_i;
            src1_q <= src1_i;
            src2_q <= src2_i;
            imm_q  <= imm_i;
            pc_q   <= pc_i;
            rd_q   <= rd_i;
            wen_q  <= wen_i;
        end
    end

    always_comb begin
        case (op_q)
            OP_MULH:  mul_kind = MK_HI_SIGNED;
            OP_MULHU: mul_kind = MK_HI_UNSIGNED;
            default:  mul_kind = MK_LO;
        endcase
        case (op_q)
            OP_DIVU: div_kind = DK_QUOT_U;
            OP_MOD:  div_kind = DK_REM_S;
            OP_MODU: div_kind = DK_REM_U;
            default: div_kind = DK_QUOT_S;
        endcase
        case (op_q)
            OP_LDB, OP_STB: mem_size = SZ_BYTE;
            OP_LDH, OP_STH: mem_size = SZ_HALF;
            default:        mem_size = SZ_WORD;
        endcase
    end

    alu u_alu (
        .op_i     (op_q),
        .src1_i   (src1_q),
        .src2_i   (src2_q),
        .imm_i    (imm_q),
        .pc_i     (pc_q),
        .logic_o  (alu_logic),
        .shift_o  (alu_shift),
        .arith_o  (alu_arith),
        .move_o   (alu_move),
        .taken_o  (alu_taken),
        .target_o (alu_target)
    );

    mul_unit u_mul (
        .clk      (clk),
        .rst      (rst),
        .start_i  (mul_start_q),
        .cancel_i (flush_i),
        .kind_i   (mul_kind),
        .a_i      (src1_q),
        .b_i      (src2_q),
        .done_o   (mul_done),
        .result_o (mul_result)
    );

    div_unit u_div (
        .clk        (clk),
        .rst        (rst),
        .start_i    (div_start_q),
        .cancel_i   (flush_i),
        .kind_i     (div_kind),
        .dividend_i (src1_q),
        .divisor_i  (src2_q),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .quot_o     (div_quot),
        .rem_o      (div_rem)
    );

    ////////////////////////////////////////////////////////////
    // Result selection and address check
    ////////////////////////////////////////////////////////////

    assign res_class = op_class(op_q);

    always_comb begin
        case (res_class)
            RES_MUL: unit_done = mul_done;
            RES_DIV: unit_done = div_done;
            default: unit_done = 1'b1;
        endcase
    end

    assign complete = busy_q && unit_done && !flush_i;

    always_comb begin
        case (res_class)
            RES_LOGIC: wdata = alu_logic;
            RES_SHIFT: wdata = alu_shift;
            RES_ARITH: wdata = alu_arith;
            RES_MOVE:  wdata = alu_move;
            RES_MUL:   wdata = mul_result;
            RES_DIV:   wdata = div_kind[1] ? div_rem : div_quot;
            RES_LINK:  wdata = pc_q + `XLEN'(4);
            default:   wdata = '0;
        endcase
    end

    assign mem_addr = src1_q + imm_q;
    assign ale = (is_load(op_q) || is_store(op_q)) &&
                 ((mem_size == SZ_HALF && mem_addr[0]) ||
                  (mem_size == SZ_WORD && mem_addr[1:0] != 2'b00));

    // Output slot
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            out_valid_o <= 1'b0;
            redirect_o  <= 1'b0;
        end else if (complete) begin
            out_valid_o <= 1'b1;
            redirect_o  <= alu_taken && is_branch(op_q);
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
            redirect_o  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            wdata_o           <= wdata;
            waddr_o           <= rd_q;
            wen_o             <= wen_q && !ale;
            mem_addr_o        <= mem_addr;
            store_data_o      <= src2_q;
            mem_load_o        <= is_load(op_q) && !ale;
            mem_store_o       <= is_store(op_q) && !ale;
            mem_size_o        <= mem_size;
            excp_ale_o        <= ale;
            redirect_target_o <= alu_target;
        end
    end

    // Stalled slot holds until the memory stage takes it
    assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i && !flush_i |=> out_valid_o &&
        $stable({wdata_o, waddr_o, wen_o, mem_addr_o, store_data_o, mem_load_o,
                 mem_store_o, mem_size_o, excp_ale_o, redirect_o, redirect_target_o}));

endmodule

// ==== dv/ex_vectors.svh ====
`ifndef EX_VECTORS_SVH
`define EX_VECTORS_SVH

// One instruction and what the output slot should hold for it
typedef struct packed {
    ex_op_e                  op;
    logic [`XLEN-1:0]        src1;
    logic [`XLEN-1:0]        src2;
    logic [`XLEN-1:0]        imm;
    logic [`XLEN-1:0]        pc;
    logic [`REG_ADDR_W-1:0]  rd;
    logic                    wen;
    logic [`XLEN-1:0]        exp_wdata;
    logic [`XLEN-1:0]        exp_addr;
    logic                    exp_ale;
    logic                    exp_redir;
    logic [`XLEN-1:0]        exp_target;
} vec_t;

localparam int NUM_VECS = 52;

// Columns: op, src1, src2, imm, pc, rd, wen,
//          wdata, address (loads and stores only), ale, redirect, target
localparam vec_t VECTORS [NUM_VECS] = '{
    '{OP_ADD,   'h7, 'h5, 'h0, 'h0, 5'd1, 1'b1, 'hc, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_SUB,   'h5, 'h7, 'h0, 'h0, 5'd2, 1'b1, 'hfffffffe, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_AND,   'hf0f0f0f0, 'hff00ff00, 'h0, 'h0, 5'd3, 1'b1, 'hf000f000, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_OR,    'hf0f0f0f0, 'h0f0f0000, 'h0, 'h0, 5'd4, 1'b1, 'hfffff0f0, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_XOR,   'haaaa5555, 'hffff0000, 'h0, 'h0, 5'd5, 1'b1, 'h55555555, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_NOR,   'h0000ff00, 'h00ff0000, 'h0, 'h0, 5'd6, 1'b1, 'hff0000ff, 'h0, 1'b0, 1'b0, 'h0},
    // Only the low five bits of the shift amount count
    '{OP_SLL,   'h1, 'h24, 'h0, 'h0, 5'd7, 1'b1, 'h10, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_SRL,   'h80000000, 'h1f, 'h0, 'h0, 5'd8, 1'b1, 'h1, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_SRA,   'h80000010, 'h4, 'h0, 'h0, 5'd9, 1'b1, 'hf8000001, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_SLT,   'hffffffff, 'h1, 'h0, 'h0, 5'd10, 1'b1, 'h1, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_SLTU,  'hffffffff, 'h1, 'h0, 'h0, 5'd11, 1'b1, 'h0, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_LUI,   'h0, 'h12345000, 'h0, 'h0, 5'd12, 1'b1, 'h12345000, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_PCADD, 'h0, 'h2000, 'h0, 'h1c000100, 5'd13, 1'b1, 'h1c002100, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MUL,   'hfffffffe, 'h3, 'h0, 'h0, 5'd14, 1'b1, 'hfffffffa, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MULH,  'hfffffffe, 'h3, 'h0, 'h0, 5'd15, 1'b1, 'hffffffff, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MULHU, 'hfffffffe, 'h3, 'h0, 'h0, 5'd16, 1'b1, 'h2, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MUL,   'hffffffff, 'hffffffff, 'h0, 'h0, 5'd17, 1'b1, 'h1, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MULH,  'hffffffff, 'hffffffff, 'h0, 'h0, 5'd18, 1'b1, 'h0, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MULHU, 'hffffffff, 'hffffffff, 'h0, 'h0, 5'd19, 1'b1, 'hfffffffe, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_DIV,   'hfffffff9, 'h2, 'h0, 'h0, 5'd20, 1'b1, 'hfffffffd, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MOD,   'hfffffff9, 'h2, 'h0, 'h0, 5'd21, 1'b1, 'hffffffff, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_DIVU,  'hfffffff9, 'h2, 'h0, 'h0, 5'd22, 1'b1, 'h7ffffffc, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MODU,  'hfffffff9, 'h2, 'h0, 'h0, 5'd23, 1'b1, 'h1, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MOD,   'h7, 'hfffffffe, 'h0, 'h0, 5'd24, 1'b1, 'h1, 'h0, 1'b0, 1'b0, 'h0},
    // Divide by zero
    '{OP_DIV,   'h1234, 'h0, 'h0, 'h0, 5'd25, 1'b1, 'hffffffff, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MOD,   'hfffffff9, 'h0, 'h0, 'h0, 5'd26, 1'b1, 'hfffffff9, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MODU,  'h1234, 'h0, 'h0, 'h0, 5'd27, 1'b1, 'h1234, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_DIV,   'h80000000, 'hffffffff, 'h0, 'h0, 5'd28, 1'b1, 'h80000000, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_MOD,   'h80000000, 'hffffffff, 'h0, 'h0, 5'd29, 1'b1, 'h0, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_LDW,   'h1000, 'h0, 'h8, 'h0, 5'd30, 1'b1, 'h0, 'h1008, 1'b0, 1'b0, 'h0},
    '{OP_LDW,   'h1000, 'h0, 'h2, 'h0, 5'd31, 1'b1, 'h0, 'h1002, 1'b1, 1'b0, 'h0},
    '{OP_LDH,   'h1000, 'h0, 'h3, 'h0, 5'd1, 1'b1, 'h0, 'h1003, 1'b1, 1'b0, 'h0},
    '{OP_LDH,   'h1000, 'h0, 'h2, 'h0, 5'd2, 1'b1, 'h0, 'h1002, 1'b0, 1'b0, 'h0},
    '{OP_LDB,   'h1000, 'h0, 'h3, 'h0, 5'd3, 1'b1, 'h0, 'h1003, 1'b0, 1'b0, 'h0},
    '{OP_STW,   'h2000, 'hdeadbeef, 'h4, 'h0, 5'd0, 1'b0, 'h0, 'h2004, 1'b0, 1'b0, 'h0},
    '{OP_STH,   'h2000, 'h0000beef, 'h1, 'h0, 5'd0, 1'b0, 'h0, 'h2001, 1'b1, 1'b0, 'h0},
    '{OP_STB,   'h2000, 'h000000ef, 'h7, 'h0, 5'd0, 1'b0, 'h0, 'h2007, 1'b0, 1'b0, 'h0},
    '{OP_STW,   'h2000, 'hcafef00d, 'h6, 'h0, 5'd0, 1'b0, 'h0, 'h2006, 1'b1, 1'b0, 'h0},
    '{OP_BEQ,   'h5, 'h5, 'h40, 'h1c000000, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b1, 'h1c000040},
    '{OP_BEQ,   'h5, 'h6, 'h40, 'h1c000000, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_BNE,   'h5, 'h6, 'hfffffff0, 'h1c000100, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b1, 'h1c0000f0},
    '{OP_BNE,   'h5, 'h5, 'hfffffff0, 'h1c000100, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_BLT,   'hffffffff, 'h1, 'h8, 'h1c000200, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b1, 'h1c000208},
    '{OP_BLT,   'h1, 'hffffffff, 'h8, 'h1c000200, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_BGE,   'h1, 'hffffffff, 'h10, 'h1c000300, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b1, 'h1c000310},
    '{OP_BGE,   'hffffffff, 'h1, 'h10, 'h1c000300, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_BLTU,  'h1, 'hffffffff, 'hc, 'h1c000400, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b1, 'h1c00040c},
    '{OP_BLTU,  'hffffffff, 'h1, 'hc, 'h1c000400, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_BGEU,  'hffffffff, 'h1, 'h20, 'h1c000500, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b1, 'h1c000520},
    '{OP_BGEU,  'h1, 'hffffffff, 'h20, 'h1c000500, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b0, 'h0},
    '{OP_JIRL,  'h1c008000, 'h0, 'h14, 'h1c000600, 5'd1, 1'b1, 'h1c000604, 'h0, 1'b0, 1'b1,
      'h1c008014},
    '{OP_NOP,   'h0, 'h0, 'h0, 'h0, 5'd0, 1'b0, 'h0, 'h0, 1'b0, 1'b0, 'h0}
};

// Divide cut off by a flush, then a remainder on the same operands
localparam vec_t FLUSHED_DIV = '{OP_DIV, 'h64, 'h7, 'h0, 'h0, 5'd9, 1'b1, 'he, 'h0, 1'b0, 1'b0, 'h0};
localparam vec_t AFTER_FLUSH = '{OP_MOD, 'h64, 'h7, 'h0, 'h0, 5'd10, 1'b1, 'h2, 'h0, 1'b0, 1'b0, 'h0};

`endif

// ==== dv/tb_ex_stage.sv ====
`include "ex_macros.svh"

module tb_ex_stage;
    timeunit 1ns;
    timeprecision 100ps;

    import ex_op_pkg::*;
    import ex_bus_pkg::*;

`include "ex_vectors.svh"

    localparam int SNAP_W      = 4*`XLEN + `REG_ADDR_W + 7;
    localparam int READY_LIMIT = 50;
    localparam int VALID_LIMIT = 100;

    logic                    clk;
    logic                    rst;
    logic                    flush;
    logic                    in_valid;
    logic                    in_ready;
    ex_op_e                  op;
    logic [`XLEN-1:0]        src1;
    logic [`XLEN-1:0]        src2;
    logic [`XLEN-1:0]        imm;
    logic [`XLEN-1:0]        pc;
    logic [`REG_ADDR_W-1:0]  rd;
    logic                    wen;
    logic                    out_valid;
    logic                    out_ready;
    logic [`XLEN-1:0]        wdata;
    logic [`REG_ADDR_W-1:0]  waddr;
    logic                    wen_out;
    logic [`XLEN-1:0]        mem_addr;
    logic [`XLEN-1:0]        store_data;
    logic                    mem_load;
    logic                    mem_store;
    mem_size_e               mem_size;
    logic                    excp_ale;
    logic                    redirect;
    logic [`XLEN-1:0]        redirect_target;

    integer seed = 32'hc059;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    bit     aborted = 1'b0;

    ex_stage DUT (
        .clk               (clk),
        .rst               (rst),
        .flush_i           (flush),
        .in_valid_i        (in_valid),
        .in_ready_o        (in_ready),
        .op_i              (op),
        .src1_i            (src1),
        .src2_i            (src2),
        .imm_i             (imm),
        .pc_i              (pc),
        .rd_i              (rd),
        .wen_i             (wen),
        .out_valid_o       (out_valid),
        .out_ready_i       (out_ready),
        .wdata_o           (wdata),
        .waddr_o           (waddr),
        .wen_o             (wen_out),
        .mem_addr_o        (mem_addr),
        .store_data_o      (store_data),
        .mem_load_o        (mem_load),
        .mem_store_o       (mem_store),
        .mem_size_o        (mem_size),
        .excp_ale_o        (excp_ale),
        .redirect_o        (redirect),
        .redirect_target_o (redirect_target)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reporting and waits
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(string name, logic [SNAP_W-1:0] exp, logic [SNAP_W-1:0] got);
        $display("[ERROR] %s expected 'h%0h got 'h%0h", name, exp, got);
        errors++;
    endtask

    task automatic report_failure(string what);
        $display("Error: %s", what);
        errors++;
    endtask

    task automatic wait_in_ready(output bit ok);
        int n;
        n = 0;
        while (!in_ready && n < READY_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = in_ready;
    endtask

    task automatic wait_out_valid(output bit ok);
        int n;
        n = 0;
        while (!out_valid && n < VALID_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = out_valid;
    endtask

    function automatic logic [SNAP_W-1:0] slot_snapshot();
        return {wdata, waddr, wen_out, mem_addr, store_data, mem_load, mem_store,
                mem_size, excp_ale, redirect, redirect_target};
    endfunction

    task automatic drive_inputs(input vec_t v);
        op       = v.op;
        src1     = v.src1;
        src2     = v.src2;
        imm      = v.imm;
        pc       = v.pc;
        rd       = v.rd;
        wen      = v.wen;
        in_valid = 1'b1;
    endtask

    task automatic check_slot(input vec_t v);
        logic      is_ld;
        logic      is_st;
        logic      exp_wen;
        logic      exp_load;
        logic      exp_store;
        mem_size_e size_exp;
        is_ld = v.op inside {OP_LDB, OP_LDH, OP_LDW};
        is_st = v.op inside {OP_STB, OP_STH, OP_STW};
        // Misaligned access suppresses all side effects
        exp_wen   = v.wen && !v.exp_ale;
        exp_load  = is_ld && !v.exp_ale;
        exp_store = is_st && !v.exp_ale;
        case (v.op)
            OP_LDB, OP_STB: size_exp = SZ_BYTE;
            OP_LDH, OP_STH: size_exp = SZ_HALF;
            default:        size_exp = SZ_WORD;
        endcase
        if (wdata !== v.exp_wdata) report_mismatch("wdata_o", v.exp_wdata, wdata);
        if (waddr !== v.rd) report_mismatch("waddr_o", v.rd, waddr);
        if (wen_out !== exp_wen) report_mismatch("wen_o", exp_wen, wen_out);
        if (mem_load !== exp_load) report_mismatch("mem_load_o", exp_load, mem_load);
        if (mem_store !== exp_store) report_mismatch("mem_store_o", exp_store, mem_store);
        if (excp_ale !== v.exp_ale) report_mismatch("excp_ale_o", v.exp_ale, excp_ale);
        if (redirect !== v.exp_redir) report_mismatch("redirect_o", v.exp_redir, redirect);
        if (v.exp_redir && redirect_target !== v.exp_target) begin
            report_mismatch("redirect_target_o", v.exp_target, redirect_target);
        end
        if ((is_ld || is_st) && mem_addr !== v.exp_addr) begin
            report_mismatch("mem_addr_o", v.exp_addr, mem_addr);
        end
        if ((is_ld || is_st) && mem_size !== size_exp) begin
            report_mismatch("mem_size_o", size_exp, mem_size);
        end
        if (is_st && store_data !== v.src2) report_mismatch("store_data_o", v.src2, store_data);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////////////////////////

    task automatic run_vector(input vec_t v, input int idx);
        bit                ok;
        int                stall;
        int                errs_before;
        logic [SNAP_W-1:0] snap;
        errs_before = errors;
        tests_run++;
        @(negedge clk);
        drive_inputs(v);
        wait_in_ready(ok);
        if (!ok) begin
            report_failure("in_ready_o never rose, instruction not accepted");
            aborted = 1'b1;
        end else begin
            @(negedge clk);
            in_valid = 1'b0;
            wait_out_valid(ok);
            if (!ok) begin
                report_failure("out_valid_o never rose, no result from the stage");
                aborted = 1'b1;
            end else begin
                check_slot(v);
                if (in_ready) report_failure("in_ready_o high while the output slot is full");
                snap = slot_snapshot();
                // Memory stage holds off for a few cycles
                stall = $random(seed) & 3;
                repeat (stall) begin
                    @(negedge clk);
                    if (!out_valid) report_failure("out_valid_o dropped while out_ready_i was low");
                    if (in_ready) report_failure("in_ready_o rose while the slot was stalled");
                    if (slot_snapshot() !== snap) begin
                        report_mismatch("output slot", snap, slot_snapshot());
                    end
                end
                out_ready = 1'b1;
                @(negedge clk);
                out_ready = 1'b0;
                if (out_valid) report_failure("output slot did not drain");
            end
        end
        if (errors != errs_before) tests_failed++;
        $display("test %0d %s: %s", idx, op.name(), (errors == errs_before) ? "ok" : "error");
    endtask

    task automatic flush_during_divide();
        bit ok;
        int errs_before;
        errs_before = errors;
        tests_run++;
        @(negedge clk);
        drive_inputs(FLUSHED_DIV);
        wait_in_ready(ok);
        if (!ok) begin
            report_failure("in_ready_o never rose before the flush test");
            aborted = 1'b1;
        end else begin
            @(negedge clk);
            in_valid = 1'b0;
            // Divider is partway through its iterations here
            repeat (8) @(negedge clk);
            if (in_ready) report_failure("in_ready_o high while the divide was running");
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            if (in_ready !== 1'b1) report_failure("in_ready_o still low after flush");
            repeat (2 * `DIV_STEPS) begin
                @(negedge clk);
                if (out_valid) report_failure("out_valid_o rose for a flushed divide");
            end
        end
        if (errors != errs_before) tests_failed++;
        $display("test flush during DIV: %s", (errors == errs_before) ? "ok" : "error");
    endtask

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        op        = OP_NOP;
        src1      = '0;
        src2      = '0;
        imm       = '0;
        pc        = '0;
        rd        = '0;
        wen       = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        tests_run++;
        if (out_valid !== 1'b0) report_mismatch("out_valid_o", 1'b0, out_valid);
        if (redirect !== 1'b0) report_mismatch("redirect_o", 1'b0, redirect);
        if (in_ready !== 1'b1) report_mismatch("in_ready_o", 1'b1, in_ready);
        if (errors != 0) tests_failed++;
        $display("test reset: %s", (errors == 0) ? "ok" : "error");

        for (int i = 0; i < NUM_VECS; i++) begin
            if (!aborted) run_vector(VECTORS[i], i);
        end
        if (!aborted) flush_during_divide();
        if (!aborted) run_vector(AFTER_FLUSH, NUM_VECS + 1);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (aborted || errors != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hdl
+incdir+dv
hdl/ex_op_pkg.sv
hdl/ex_bus_pkg.sv
hdl/alu.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/ex_stage.sv
dv/tb_ex_stage.sv
